// File: source/stq_config.svh
// store queue configuration
// depth, index width and the address and data widths shared by all blocks
`ifndef STQ_CONFIG_SVH
`define STQ_CONFIG_SVH

// entries in the circular buffer, one slot stays free
`define STQ_DEPTH 16

// entry index width
`define STQ_IDX_W 4

// word address width
`define STQ_ADDR_W 30

// store data width
`define STQ_DATA_W 32

// bytes per word, also the byte mask width
`define STQ_BYTES 4

`endif

// File: source/stq_pkg.sv
// store queue types
// address, data, port and result structs used across the queue
`default_nettype none

`include "stq_config.svh"

package stq_pkg;

  typedef struct packed {
    logic [`STQ_ADDR_W-1:0] word;
    logic [`STQ_BYTES-1:0]  mask;  // one bit per byte lane
  } stq_addr_t;

  typedef logic [`STQ_DATA_W-1:0] stq_data_t;

  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;

  typedef struct packed {
    logic      en;
    stq_idx_t  idx;
    stq_addr_t addr;
  } stq_wrt_t;  // store address write

  typedef struct packed {
    logic      en;
    stq_idx_t  idx;
    stq_data_t data;
  } stq_upd_t;  // store data write

  typedef struct packed {
    logic      en;
    stq_addr_t addr;
    stq_idx_t  tag;  // first store younger than the load
  } stq_chk_t;

  typedef struct packed {
    logic      en;
    logic      hit;
    logic      partial;
    stq_data_t data;
  } stq_res_t;

  typedef struct packed {
    logic      en;
    stq_addr_t addr;
    stq_data_t data;
  } stq_wb_t;

endpackage

`default_nettype wire

// File: source/stq_field_array.sv
// store queue field array
// one field per entry with a valid bit, written by index and cleared by a
// one-hot vector; all entries are visible at once for the search
`timescale 1ns/1ps
`default_nettype none

`include "stq_config.svh"

module stq_field_array import stq_pkg::*; #(
  parameter type payload_t = stq_data_t
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr_en,
  input  stq_idx_t                      wr_idx,
  input  payload_t                      wr_payload,
  input  logic [`STQ_DEPTH-1:0]         clr,
  output payload_t [`STQ_DEPTH-1:0]     entries,
  output logic [`STQ_DEPTH-1:0]         valid
);

  payload_t [`STQ_DEPTH-1:0] mem;
  logic [`STQ_DEPTH-1:0]     valid_q;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_payload;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_q & ~clr;  // retired entries drop out
      if (wr_en) begin
        valid_q[wr_idx] <= 1'b1;
      end
    end
  end

  assign entries = mem;
  assign valid   = valid_q;

endmodule

`default_nettype wire

// File: source/stq_find_last.sv
// find last set bit
// returns the highest set bit of req as a one-hot vector and a found flag
`timescale 1ns/1ps
`default_nettype none

module stq_find_last #(
  parameter int WIDTH = 16
) (
  input  logic [WIDTH-1:0] req,
  output logic [WIDTH-1:0] onehot,
  output logic             found
);

  logic seen;

  always_comb begin
    seen = 1'b0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      onehot[i] = req[i] & ~seen;  // nothing higher taken yet
      seen      = seen | req[i];
    end
  end

  assign found = |req;

endmodule

`default_nettype wire

// File: source/stq_forward_check.sv
// store queue load check port
// searches the older stores for the youngest one that overlaps the load,
// decides between a full hit and a partial match, result one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "stq_config.svh"

module stq_forward_check import stq_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  stq_chk_t                       chk,
  input  stq_idx_t                       head,
  input  stq_addr_t [`STQ_DEPTH-1:0]     addrs,
  input  logic [`STQ_DEPTH-1:0]          addr_valid,
  input  stq_data_t [`STQ_DEPTH-1:0]     datas,
  input  logic [`STQ_DEPTH-1:0]          data_valid,
  output stq_res_t                       res
);

  logic [`STQ_DEPTH-1:0] below_tag;
  logic [`STQ_DEPTH-1:0] at_head;
  logic [`STQ_DEPTH-1:0] older;
  logic [`STQ_DEPTH-1:0] match;
  logic [`STQ_DEPTH-1:0] cand;
  logic [`STQ_DEPTH-1:0] lo_onehot;
  logic [`STQ_DEPTH-1:0] hi_onehot;
  logic [`STQ_DEPTH-1:0] sel;
  logic                  lo_found;
  logic                  hi_found;
  logic                  wrap;

  logic [`STQ_BYTES-1:0] sel_mask;
  stq_data_t             sel_data;
  logic                  sel_dvalid;
  logic                  covers;
  logic                  hit_c;
  logic                  partial_c;

  logic                  res_en_q;
  logic                  res_hit_q;
  logic                  res_partial_q;
  stq_data_t             res_data_q;

  for (genvar i = 0; i < `STQ_DEPTH; i++) begin : g_ent
    assign below_tag[i] = stq_idx_t'(i) < chk.tag;
    assign at_head[i]   = stq_idx_t'(i) >= head;
    assign match[i]     = addr_valid[i] && (addrs[i].word == chk.addr.word) &&
                          |(addrs[i].mask & chk.addr.mask);
  end

  assign wrap  = head > chk.tag;  // older range runs past the top entry
  assign older = wrap ? (at_head | below_tag) : (at_head & below_tag);
  assign cand  = match & older;

  // youngest first: below the tag, then the wrapped part from the head up
  stq_find_last #(.WIDTH(`STQ_DEPTH)) lo_find (
    .req    (cand & below_tag),
    .onehot (lo_onehot),
    .found  (lo_found)
  );

  stq_find_last #(.WIDTH(`STQ_DEPTH)) hi_find (
    .req    (cand & ~below_tag),
    .onehot (hi_onehot),
    .found  (hi_found)
  );

  assign sel = lo_found ? lo_onehot : hi_onehot;

  always_comb begin
    sel_mask   = '0;
    sel_data   = '0;
    sel_dvalid = 1'b0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      if (sel[i]) begin
        sel_mask   = sel_mask | addrs[i].mask;
        sel_data   = sel_data | datas[i];
        sel_dvalid = sel_dvalid | data_valid[i];
      end
    end
  end

  assign covers    = (sel_mask & chk.addr.mask) == chk.addr.mask;
  assign hit_c     = (lo_found | hi_found) & covers & sel_dvalid;
  assign partial_c = (lo_found | hi_found) & ~hit_c;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_en_q      <= 1'b0;
      res_hit_q     <= 1'b0;
      res_partial_q <= 1'b0;
    end else begin
      res_en_q      <= chk.en;
      res_hit_q     <= chk.en & hit_c;
      res_partial_q <= chk.en & partial_c;
    end
  end

  always_ff @(posedge clk) begin
    res_data_q <= sel_data;
  end

  assign res = '{en: res_en_q, hit: res_hit_q, partial: res_partial_q, data: res_data_q};

endmodule

`default_nettype wire

// File: source/stq_retire.sv
// store queue retire
// keeps the head pointer pair, clears retired entries and sends the one or
// two oldest stores to the cache write-back ports
`timescale 1ns/1ps
`default_nettype none

`include "stq_config.svh"

module stq_retire import stq_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           stall,
  input  logic                           pse0_en,
  input  logic                           pse1_en,
  input  stq_addr_t [`STQ_DEPTH-1:0]     addrs,
  input  stq_data_t [`STQ_DEPTH-1:0]     datas,
  output stq_idx_t                       head,
  output logic [`STQ_DEPTH-1:0]          clr,
  output stq_wb_t                        wb0,
  output stq_wb_t                        wb1
);

  stq_idx_t  head0_q;
  stq_idx_t  head1_q;  // always head0_q + 1
  logic      accept0;
  logic      accept1;

  logic      wb0_en_q;
  logic      wb1_en_q;
  stq_addr_t wb0_addr_q;
  stq_addr_t wb1_addr_q;
  stq_data_t wb0_data_q;
  stq_data_t wb1_data_q;

  assign accept0 = pse0_en & ~stall;
  assign accept1 = accept0 & pse1_en;  // second slot only with the first

  always_comb begin
    clr = '0;
    if (accept0) begin
      clr[head0_q] = 1'b1;
    end
    if (accept1) begin
      clr[head1_q] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head0_q  <= '0;
      head1_q  <= stq_idx_t'(1);
      wb0_en_q <= 1'b0;
      wb1_en_q <= 1'b0;
    end else begin
      wb0_en_q <= accept0;
      wb1_en_q <= accept1;
      if (accept1) begin
        head0_q <= head1_q + 1'b1;
        head1_q <= head1_q + 2'd2;
      end else if (accept0) begin
        head0_q <= head1_q;
        head1_q <= head1_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept0) begin
      wb0_addr_q <= addrs[head0_q];
      wb0_data_q <= datas[head0_q];
    end
    if (accept1) begin
      wb1_addr_q <= addrs[head1_q];
      wb1_data_q <= datas[head1_q];
    end
  end

  assign head = head0_q;
  assign wb0  = '{en: wb0_en_q, addr: wb0_addr_q, data: wb0_data_q};
  assign wb1  = '{en: wb1_en_q, addr: wb1_addr_q, data: wb1_data_q};

endmodule

`default_nettype wire

// File: source/stq_top.sv
// store queue top
// address and data arrays, two load check ports and the retire path
`timescale 1ns/1ps
`default_nettype none

`include "stq_config.svh"

module stq_top import stq_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall,
  input  stq_wrt_t wrt,
  input  stq_upd_t upd,
  input  stq_chk_t chk0,
  input  stq_chk_t chk1,
  input  logic     pse0_en,
  input  logic     pse1_en,
  output stq_res_t res0,
  output stq_res_t res1,
  output stq_wb_t  wb0,
  output stq_wb_t  wb1
);

  stq_addr_t [`STQ_DEPTH-1:0] addrs;
  stq_data_t [`STQ_DEPTH-1:0] datas;
  logic [`STQ_DEPTH-1:0]      addr_valid;
  logic [`STQ_DEPTH-1:0]      data_valid;
  logic [`STQ_DEPTH-1:0]      clr;
  stq_idx_t                   head;

  stq_field_array #(.payload_t(stq_addr_t)) addr_array (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wrt.en),
    .wr_idx     (wrt.idx),
    .wr_payload (wrt.addr),
    .clr        (clr),
    .entries    (addrs),
    .valid      (addr_valid)
  );

  stq_field_array #(.payload_t(stq_data_t)) data_array (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (upd.en),
    .wr_idx     (upd.idx),
    .wr_payload (upd.data),
    .clr        (clr),
    .entries    (datas),
    .valid      (data_valid)
  );

  stq_forward_check chk0_unit (
    .clk        (clk),
    .rst        (rst),
    .chk        (chk0),
    .head       (head),
    .addrs      (addrs),
    .addr_valid (addr_valid),
    .datas      (datas),
    .data_valid (data_valid),
    .res        (res0)
  );

  stq_forward_check chk1_unit (
    .clk        (clk),
    .rst        (rst),
    .chk        (chk1),
    .head       (head),
    .addrs      (addrs),
    .addr_valid (addr_valid),
    .datas      (datas),
    .data_valid (data_valid),
    .res        (res1)
  );

  // retire ignores the valid bits, upstream only retires complete stores
  stq_retire retire_unit (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .pse0_en (pse0_en),
    .pse1_en (pse1_en),
    .addrs   (addrs),
    .datas   (datas),
    .head    (head),
    .clr     (clr),
    .wb0     (wb0),
    .wb1     (wb1)
  );

endmodule

`default_nettype wire

// File: verification/stq_checker.sv
// store queue checker
// protocol assertions on the check and retire ports of the queue
`timescale 1ns/1ps
`default_nettype none

module stq_checker import stq_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     stall,
  input logic     pse0_en,
  input logic     pse1_en,
  input stq_chk_t chk0,
  input stq_chk_t chk1,
  input stq_res_t res0,
  input stq_res_t res1,
  input stq_wb_t  wb0,
  input stq_wb_t  wb1
);

  a_res0_excl: assert property (@(posedge clk) disable iff (rst) !(res0.hit && res0.partial))
    else $error("res0 reports hit and partial together");
  a_res1_excl: assert property (@(posedge clk) disable iff (rst) !(res1.hit && res1.partial))
    else $error("res1 reports hit and partial together");
  a_res0_lat: assert property (@(posedge clk) disable iff (rst) chk0.en |=> res0.en)
    else $error("res0 did not follow chk0 by one cycle");
  a_res1_lat: assert property (@(posedge clk) disable iff (rst) chk1.en |=> res1.en)
    else $error("res1 did not follow chk1 by one cycle");
  a_wb0_lat: assert property (@(posedge clk) disable iff (rst) (pse0_en && !stall) |=> wb0.en)
    else $error("wb0 did not follow an accepted retire");
  a_wb1_lat: assert property (@(posedge clk) disable iff (rst)
    (pse0_en && pse1_en && !stall) |=> wb1.en)
    else $error("wb1 did not follow an accepted double retire");

endmodule

bind stq_top stq_checker checks (.*);

`default_nettype wire

// File: verification/stq_tb.sv
// store queue testbench
// directed table of writes, checks and retires, then a random phase
// compared against a reference model of the queue
`timescale 1ns/1ps
`default_nettype none

`include "stq_config.svh"

module stq_tb import stq_pkg::*;;

  localparam int OP_WA = 0, OP_WD = 1, OP_CHK = 2, OP_RET1 = 3, OP_RET2 = 4, OP_STALL = 5;

  typedef struct packed {
    logic [2:0]             op;
    stq_idx_t               idx;
    logic [`STQ_ADDR_W-1:0] word;
    logic [`STQ_BYTES-1:0]  mask;
    stq_data_t              data;
    stq_idx_t               tag;
    logic                   hit;
    logic                   partial;
    stq_data_t              exp_data;  // check data or wb0 data
  } row_t;

  logic clk, rst, stall, pse0_en, pse1_en;
  stq_wrt_t wrt;
  stq_upd_t upd;
  stq_chk_t chk0, chk1;
  stq_res_t res0, res1;
  stq_wb_t  wb0, wb1;

  stq_addr_t m_addr [`STQ_DEPTH];
  stq_data_t m_data [`STQ_DEPTH];
  logic      m_aval [`STQ_DEPTH];
  logic      m_dval [`STQ_DEPTH];
  stq_idx_t  m_head, m_tail;
  row_t      rows[$];
  int        errors, timeouts;
  logic [31:0] seed;

  stq_top DUT (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic row_t make_row(input int op, input int idx, input int word, input int mask,
      input logic [31:0] data, input int tag, input int hit, input int partial,
      input logic [31:0] exp_data);
    return '{op: op, idx: idx, word: word, mask: mask, data: data, tag: tag, hit: hit,
             partial: partial, exp_data: exp_data};
  endfunction

  // walk back from the tag to the head, first overlap decides
  task automatic model_check(input stq_addr_t a, input stq_idx_t tag, output logic hit,
      output logic partial, output stq_data_t data);
    stq_idx_t i;
    i = tag;
    hit = 0;
    partial = 0;
    data = '0;
    while (i != m_head) begin
      i = i - 1'b1;
      if (m_aval[i] && m_addr[i].word == a.word && (m_addr[i].mask & a.mask) != 0) begin
        if ((m_addr[i].mask & a.mask) == a.mask && m_dval[i]) begin
          hit = 1;
          data = m_data[i];
        end else begin
          partial = 1;
        end
        break;
      end
    end
  endtask

  task automatic model_retire(input int n, output stq_wb_t e0, output stq_wb_t e1);
    e0 = '{en: n > 0, addr: m_addr[m_head], data: m_data[m_head]};
    e1 = '{en: n > 1, addr: m_addr[m_head + 1'b1], data: m_data[m_head + 1'b1]};
    repeat (n) begin
      m_aval[m_head] = 0;
      m_dval[m_head] = 0;
      m_head = m_head + 1'b1;
    end
  endtask

  task automatic idle_inputs();
    wrt = '0;
    upd = '0;
    chk0 = '0;
    chk1 = '0;
    pse0_en = 0;
    pse1_en = 0;
    stall = 0;
  endtask

  task automatic compare_res(input string name, input stq_res_t got, input logic hit,
      input logic partial, input stq_data_t data);
    if (got.hit !== hit || got.partial !== partial || (hit && got.data !== data)) begin
      errors++;
      $display("Error at %0t: %s hit %b partial %b data %h, expected %b %b %h", $time, name,
               got.hit, got.partial, got.data, hit, partial, data);
    end
  endtask

  task automatic compare_wb(input string name, input stq_wb_t got, input stq_wb_t exp);
    if (got.en !== exp.en || (exp.en && (got.addr !== exp.addr || got.data !== exp.data))) begin
      errors++;
      $display("Error at %0t: %s en %b addr %h data %h, expected %b %h %h", $time, name,
               got.en, got.addr, got.data, exp.en, exp.addr, exp.data);
    end
  endtask

  task automatic apply_row(input row_t r);
    stq_wb_t e0, e1;
    int cnt;
    idle_inputs();
    case (r.op)
      OP_WA: wrt = '{en: 1'b1, idx: r.idx, addr: '{word: r.word, mask: r.mask}};
      OP_WD: upd = '{en: 1'b1, idx: r.idx, data: r.data};
      OP_RET1, OP_RET2: begin
        pse0_en = 1;
        pse1_en = (r.op == OP_RET2);
        model_retire(r.op == OP_RET2 ? 2 : 1, e0, e1);
        e0.data = r.exp_data;
      end
      default: begin
        chk0 = '{en: 1'b1, addr: '{word: r.word, mask: r.mask}, tag: r.tag};
        chk1 = chk0;
        if (r.op == OP_STALL) begin
          stall = 1;
          pse0_en = 1;
          pse1_en = 1;
        end
      end
    endcase
    @(negedge clk);
    idle_inputs();
    if (r.op == OP_WA) begin
      m_addr[r.idx] = '{word: r.word, mask: r.mask};
      m_aval[r.idx] = 1;
      m_tail = r.idx + 1'b1;
    end else if (r.op == OP_WD) begin
      m_data[r.idx] = r.data;
      m_dval[r.idx] = 1;
    end else if (r.op == OP_RET1 || r.op == OP_RET2) begin
      cnt = 0;
      while (!wb0.en && cnt < 8) begin
        @(negedge clk);
        cnt++;
      end
      if (cnt == 8) begin
        timeouts++;
        $display("write-back did not arrive in time at %0t", $time);
      end else begin
        compare_wb("wb0", wb0, e0);
        compare_wb("wb1", wb1, e1);
      end
    end else begin
      if (r.op == OP_STALL && (wb0.en || wb1.en)) begin
        errors++;
        $display("Error at %0t: write-back while stalled", $time);
      end
      cnt = 0;
      while (!res0.en && cnt < 8) begin
        @(negedge clk);
        cnt++;
      end
      if (cnt == 8 || !res1.en) begin
        timeouts++;
        $display("check result did not arrive in time at %0t", $time);
      end else begin
        compare_res("res0", res0, r.hit, r.partial, r.exp_data);
        compare_res("res1", res1, r.hit, r.partial, r.exp_data);
      end
    end
  endtask

  task automatic random_cycle();
    stq_idx_t cnt, k, tag0, tag1;
    stq_addr_t a0, a1;
    logic h0, p0, h1, p1;
    stq_data_t d0, d1;
    stq_wb_t e0, e1;
    logic [31:0] r;
    idle_inputs();
    cnt = m_tail - m_head;
    seed = xorshift(seed);
    r = seed;
    if (cnt < `STQ_DEPTH - 1 && r[0]) begin
      wrt = '{en: 1'b1, idx: m_tail, addr: '{word: r[3:2], mask: r[7:4] == 0 ? 4'hf : r[7:4]}};
    end
    k = m_head + (cnt == 0 ? 0 : r[11:8] % cnt);
    if (cnt > 0 && r[12] && m_aval[k] && !m_dval[k]) begin
      seed = xorshift(seed);
      upd = '{en: 1'b1, idx: k, data: seed};
    end
    stall = r[13];
    if (r[14] && cnt >= 1 && m_aval[m_head] && m_dval[m_head]) begin
      pse0_en = 1;
      pse1_en = r[15] && cnt >= 2 && m_aval[m_head + 1'b1] && m_dval[m_head + 1'b1];
    end
    seed = xorshift(seed);
    tag0 = m_head + seed[3:0] % (cnt + 5'd1);
    tag1 = m_head + seed[7:4] % (cnt + 5'd1);
    a0 = '{word: seed[9:8], mask: seed[15:12] == 0 ? 4'h1 : seed[15:12]};
    a1 = '{word: seed[11:10], mask: seed[19:16] == 0 ? 4'h8 : seed[19:16]};
    chk0 = '{en: 1'b1, addr: a0, tag: tag0};
    chk1 = '{en: 1'b1, addr: a1, tag: tag1};
    model_check(a0, tag0, h0, p0, d0);
    model_check(a1, tag1, h1, p1, d1);
    model_retire(pse0_en && !stall ? (pse1_en ? 2 : 1) : 0, e0, e1);
    @(negedge clk);
    if (wrt.en) begin
      m_addr[wrt.idx] = wrt.addr;
      m_aval[wrt.idx] = 1;
      m_tail = m_tail + 1'b1;
    end
    if (upd.en) begin
      m_data[upd.idx] = upd.data;
      m_dval[upd.idx] = 1;
    end
    if (!res0.en || !res1.en) begin
      errors++;
      $display("Error at %0t: check result enable missing", $time);
    end
    compare_res("res0", res0, h0, p0, d0);
    compare_res("res1", res1, h1, p1, d1);
    compare_wb("wb0", wb0, e0);
    compare_wb("wb1", wb1, e1);
  endtask

  initial begin
    clk = 0;
    rst = 1;
    idle_inputs();
    errors = 0;
    timeouts = 0;
    seed = 32'h07ae_e34e;
    m_head = 0;
    m_tail = 0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      m_aval[i] = 0;
      m_dval[i] = 0;
    end
    rows.push_back(make_row(OP_CHK, 0, 5, 'hf, 0, 0, 0, 0, 0));
    rows.push_back(make_row(OP_WA, 0, 5, 'hf, 0, 0, 0, 0, 0));
    rows.push_back(make_row(OP_CHK, 0, 5, 'h3, 0, 1, 0, 1, 0));  // data missing
    rows.push_back(make_row(OP_WD, 0, 0, 0, 32'h1111_1111, 0, 0, 0, 0));
    rows.push_back(make_row(OP_CHK, 0, 5, 'h3, 0, 1, 1, 0, 32'h1111_1111));
    rows.push_back(make_row(OP_WA, 1, 5, 'h1, 0, 0, 0, 0, 0));
    rows.push_back(make_row(OP_WD, 1, 0, 0, 32'h2222_2222, 0, 0, 0, 0));
    rows.push_back(make_row(OP_CHK, 0, 5, 'h3, 0, 2, 0, 1, 0));  // youngest only covers part
    rows.push_back(make_row(OP_CHK, 0, 5, 'h1, 0, 2, 1, 0, 32'h2222_2222));
    rows.push_back(make_row(OP_CHK, 0, 5, 'h1, 0, 1, 1, 0, 32'h1111_1111));
    rows.push_back(make_row(OP_STALL, 0, 5, 'h4, 0, 2, 1, 0, 32'h1111_1111));
    rows.push_back(make_row(OP_RET1, 0, 0, 0, 0, 0, 0, 0, 32'h1111_1111));
    rows.push_back(make_row(OP_CHK, 0, 5, 'h4, 0, 2, 0, 0, 0));
    for (int i = 2; i < 15; i++) begin
      rows.push_back(make_row(OP_WA, i, 9, 'hf, 0, 0, 0, 0, 0));
      rows.push_back(make_row(OP_WD, i, 0, 0, 32'h100 + i, 0, 0, 0, 0));
    end
    rows.push_back(make_row(OP_RET2, 0, 0, 0, 0, 0, 0, 0, 32'h2222_2222));
    for (int k = 1; k < 7; k++) begin
      rows.push_back(make_row(OP_RET2, 0, 0, 0, 0, 0, 0, 0, 32'h100 + 2 * k + 1));
    end
    rows.push_back(make_row(OP_WA, 15, 7, 'hf, 0, 0, 0, 0, 0));
    rows.push_back(make_row(OP_WD, 15, 0, 0, 32'haaaa_0000, 0, 0, 0, 0));
    rows.push_back(make_row(OP_WA, 0, 7, 'hf, 0, 0, 0, 0, 0));
    rows.push_back(make_row(OP_WD, 0, 0, 0, 32'hbbbb_0000, 0, 0, 0, 0));
    rows.push_back(make_row(OP_CHK, 0, 7, 'hf, 0, 1, 1, 0, 32'hbbbb_0000));
    rows.push_back(make_row(OP_CHK, 0, 7, 'hf, 0, 0, 1, 0, 32'haaaa_0000));
    rows.push_back(make_row(OP_CHK, 0, 7, 'h3, 0, 15, 0, 0, 0));  // empty older range
    rows.push_back(make_row(OP_RET2, 0, 0, 0, 0, 0, 0, 0, 32'haaaa_0000));
    rows.push_back(make_row(OP_CHK, 0, 7, 'hf, 0, 1, 0, 0, 0));
    repeat (2) @(negedge clk);
    rst = 0;
    if (res0.en || res1.en || wb0.en || wb1.en) begin
      errors++;
      $display("Error at %0t: output enables set after reset", $time);
    end
    foreach (rows[i]) apply_row(rows[i]);
    repeat (400) random_cycle();
    $display("errors: %0d value, %0d timeout", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/stq_pkg.sv
source/stq_field_array.sv
source/stq_find_last.sv
source/stq_forward_check.sv
source/stq_retire.sv
source/stq_top.sv
verification/stq_checker.sv
verification/stq_tb.sv
